/* hw/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_idx_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [4:0]  subop_t;
	typedef logic [7:0]  ls_subop_t;

	// major opcodes, instr[30:25]
	localparam opcode_t op_ty_base = 6'b100000;
	localparam opcode_t op_addi    = 6'b101000;
	localparam opcode_t op_ori     = 6'b101100;
	localparam opcode_t op_xori    = 6'b101011;
	localparam opcode_t op_movi    = 6'b100010;
	localparam opcode_t op_lwi     = 6'b000010;
	localparam opcode_t op_swi     = 6'b001010;
	localparam opcode_t op_ty_ls   = 6'b011100;

	// base sub-opcodes, instr[4:0]
	localparam subop_t sub_add   = 5'b00000;
	localparam subop_t sub_sub   = 5'b00001;
	localparam subop_t sub_and   = 5'b00010;
	localparam subop_t sub_xor   = 5'b00011;
	localparam subop_t sub_or    = 5'b00100;
	localparam subop_t sub_slli  = 5'b01000;
	localparam subop_t sub_srli  = 5'b01001;
	localparam subop_t sub_rotri = 5'b01011;

	localparam ls_subop_t ls_lw = 8'b00000010;
	localparam ls_subop_t ls_sw = 8'b00001010;

	typedef enum logic [1:0] {
		imm_none,
		imm_alu,
		imm_mem,
		imm_reg_scaled
	} imm_sel_e;

	typedef enum logic [1:0] {
		res_base,
		res_add_imm,
		res_logic_imm,
		res_move
	} res_sel_e;

	typedef enum logic [1:0] {
		wb_alu,
		wb_imm,
		wb_mem
	} wb_sel_e;

	typedef enum logic [2:0] {
		ph_request,
		ph_latch,
		ph_execute,
		ph_memory,
		ph_writeback
	} phase_e;

endpackage

`default_nettype wire

/* hw/ctrl_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface ctrl_if;
	import cpu_pkg::*;

	imm_sel_e imm_sel;
	res_sel_e res_sel;
	wb_sel_e  wb_sel;
	logic     dm_read;
	logic     dm_write;
	logic     reg_write;
	subop_t   sub_op;

	modport master (
		output imm_sel, res_sel, wb_sel, dm_read, dm_write, reg_write, sub_op
	);

	// memory strobes go straight to the top, not through the datapath
	modport slave (
		input imm_sel, res_sel, wb_sel, reg_write, sub_op
	);

endinterface

`default_nettype wire

/* hw/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile (
	input  logic              clock,
	input  logic              reset,
	input  cpu_pkg::reg_idx_t read_a_idx,
	input  cpu_pkg::reg_idx_t read_b_idx,
	input  cpu_pkg::reg_idx_t write_idx,
	input  logic              write_enable,
	input  cpu_pkg::word_t    write_data,
	output cpu_pkg::word_t    read_a,
	output cpu_pkg::word_t    read_b
);
	import cpu_pkg::*;

	word_t regs [32];

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (write_enable && (write_idx != 5'd0)) begin
			regs[write_idx] <= write_data;
		end
	end

	// r0 hardwired to zero
	assign read_a = (read_a_idx == 5'd0) ? '0 : regs[read_a_idx];
	assign read_b = (read_b_idx == 5'd0) ? '0 : regs[read_b_idx];

endmodule

`default_nettype wire

/* hw/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  cpu_pkg::word_t   operand_a,
	input  cpu_pkg::word_t   operand_b,
	input  cpu_pkg::res_sel_e res_sel,
	input  cpu_pkg::subop_t  sub_op,
	output cpu_pkg::word_t   result
);
	import cpu_pkg::*;

	logic [4:0]  shamt;
	logic [63:0] rot_wide;
	word_t       base_result;

	assign shamt    = operand_b[4:0];
	assign rot_wide = {operand_a, operand_a} >> shamt;

	always_comb begin
		case (sub_op)
			sub_add:   base_result = operand_a + operand_b;
			sub_sub:   base_result = operand_a - operand_b;
			sub_and:   base_result = operand_a & operand_b;
			sub_xor:   base_result = operand_a ^ operand_b;
			sub_or:    base_result = operand_a | operand_b;
			sub_slli:  base_result = operand_a << shamt;
			sub_srli:  base_result = operand_a >> shamt;
			sub_rotri: base_result = rot_wide[31:0];
			default:   base_result = '0;
		endcase
	end

	always_comb begin
		case (res_sel)
			res_base:      result = base_result;
			res_add_imm:   result = operand_a + operand_b;
			// bit 3 set means ori
			res_logic_imm: result = sub_op[3] ? (operand_a | operand_b)
			                                  : (operand_a ^ operand_b);
			default:       result = operand_b;
		endcase
	end

endmodule

`default_nettype wire

/* hw/controller.sv */
`timescale 1ns/1ps
`default_nettype none

module controller (
	input  logic          clock,
	input  logic          reset,
	input  cpu_pkg::word_t instr,
	ctrl_if.master        ctrl,
	output logic          pc_enable,
	output logic          fetch_enable,
	output logic          execute_enable,
	output logic          writeback_enable,
	output logic          im_enable,
	output logic          dm_enable
);
	import cpu_pkg::*;

	phase_e    phase;
	phase_e    next_phase;
	opcode_t   opcode;
	subop_t    subop;
	ls_subop_t ls_subop;
	imm_sel_e  imm_sel;
	res_sel_e  res_sel;
	wb_sel_e   wb_sel;
	logic      reg_write;
	logic      mem_read;
	logic      mem_write;

	assign opcode   = instr[30:25];
	assign subop    = instr[4:0];
	assign ls_subop = instr[7:0];

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			phase <= ph_request;
		end else begin
			phase <= next_phase;
		end
	end

	always_comb begin
		case (phase)
			ph_request: next_phase = ph_latch;
			ph_latch:   next_phase = ph_execute;
			ph_execute: next_phase = ph_memory;
			ph_memory:  next_phase = ph_writeback;
			default:    next_phase = ph_request;
		endcase
	end

	assign pc_enable        = (phase == ph_request);
	assign im_enable        = (phase == ph_request);
	assign fetch_enable     = (phase == ph_latch);
	assign execute_enable   = (phase == ph_execute);
	assign dm_enable        = (phase == ph_memory);
	assign writeback_enable = (phase == ph_writeback);

	always_comb begin
		imm_sel   = imm_none;
		res_sel   = res_base;
		wb_sel    = wb_alu;
		reg_write = 1'b0;
		mem_read  = 1'b0;
		mem_write = 1'b0;
		case (opcode)
			op_ty_base: begin
				case (subop)
					sub_add, sub_sub, sub_and, sub_xor, sub_or: begin
						reg_write = 1'b1;
					end
					sub_slli, sub_srli, sub_rotri: begin
						imm_sel   = imm_alu;
						reg_write = 1'b1;
					end
					default: reg_write = 1'b0;
				endcase
			end
			op_addi: begin
				imm_sel   = imm_alu;
				res_sel   = res_add_imm;
				reg_write = 1'b1;
			end
			op_ori, op_xori: begin
				imm_sel   = imm_alu;
				res_sel   = res_logic_imm;
				reg_write = 1'b1;
			end
			op_movi: begin
				imm_sel   = imm_alu;
				res_sel   = res_move;
				wb_sel    = wb_imm;
				reg_write = 1'b1;
			end
			op_lwi: begin
				imm_sel   = imm_mem;
				wb_sel    = wb_mem;
				reg_write = 1'b1;
				mem_read  = 1'b1;
			end
			op_swi: begin
				imm_sel   = imm_mem;
				mem_write = 1'b1;
			end
			op_ty_ls: begin
				case (ls_subop)
					ls_lw: begin
						imm_sel   = imm_reg_scaled;
						wb_sel    = wb_mem;
						reg_write = 1'b1;
						mem_read  = 1'b1;
					end
					ls_sw: begin
						imm_sel   = imm_reg_scaled;
						mem_write = 1'b1;
					end
					default: reg_write = 1'b0;
				endcase
			end
			default: reg_write = 1'b0;
		endcase
	end

	assign ctrl.imm_sel   = imm_sel;
	assign ctrl.res_sel   = res_sel;
	assign ctrl.wb_sel    = wb_sel;
	assign ctrl.reg_write = reg_write;
	assign ctrl.dm_read   = mem_read && (phase == ph_memory);
	assign ctrl.dm_write  = mem_write && (phase == ph_memory);

	// opcode bit 2 splits ori from xori, alu wants it in sub_op bit 3
	assign ctrl.sub_op = (res_sel == res_logic_imm) ? {1'b0, opcode[2], 3'b000} : subop;

endmodule

`default_nettype wire

/* hw/datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module datapath (
	input  logic           clock,
	input  logic           reset,
	ctrl_if.slave          ctrl,
	input  logic           pc_enable,
	input  logic           fetch_enable,
	input  logic           execute_enable,
	input  logic           writeback_enable,
	output cpu_pkg::word_t instr,
	output cpu_pkg::word_t im_addr,
	input  cpu_pkg::word_t im_rdata,
	output cpu_pkg::word_t dm_addr,
	output cpu_pkg::word_t dm_wdata,
	input  cpu_pkg::word_t dm_rdata
);
	import cpu_pkg::*;

	word_t    pc;
	word_t    ir;
	word_t    result_q;
	word_t    addr_q;
	word_t    reg_a;
	word_t    reg_b;
	word_t    alu_imm;
	word_t    operand_b;
	word_t    alu_result;
	word_t    wb_data;
	word_t    imm15_sext;
	word_t    imm15_zext;
	word_t    imm20_sext;
	word_t    shift_imm;
	reg_idx_t rt_idx;
	reg_idx_t read_b_idx;

	assign rt_idx     = ir[24:20];
	assign imm15_sext = {{17{ir[14]}}, ir[14:0]};
	assign imm15_zext = {17'd0, ir[14:0]};
	assign imm20_sext = {{12{ir[19]}}, ir[19:0]};
	assign shift_imm  = {27'd0, ir[14:10]};

	// port b reads rb while executing, rt afterwards for store data
	assign read_b_idx = execute_enable ? ir[14:10] : rt_idx;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			pc <= '0;
			ir <= '0;
		end else begin
			if (pc_enable) pc <= pc + 32'd4;
			if (fetch_enable) ir <= im_rdata;
		end
	end

	always_ff @(posedge clock) begin
		if (execute_enable) begin
			result_q <= alu_result;
			addr_q   <= reg_a + operand_b;
		end
	end

	always_comb begin
		case (ctrl.res_sel)
			res_base:      alu_imm = shift_imm;
			res_add_imm:   alu_imm = imm15_sext;
			res_logic_imm: alu_imm = imm15_zext;
			default:       alu_imm = imm20_sext;
		endcase
		case (ctrl.imm_sel)
			imm_none: operand_b = reg_b;
			imm_alu:  operand_b = alu_imm;
			imm_mem:  operand_b = imm15_sext << 2;
			default:  operand_b = reg_b << ir[9:8];
		endcase
		case (ctrl.wb_sel)
			wb_imm:  wb_data = imm20_sext;
			wb_mem:  wb_data = dm_rdata;
			default: wb_data = result_q;
		endcase
	end

	regfile regs0 (
		.clock        (clock),
		.reset        (reset),
		.read_a_idx   (ir[19:15]),
		.read_b_idx   (read_b_idx),
		.write_idx    (rt_idx),
		.write_enable (writeback_enable && ctrl.reg_write),
		.write_data   (wb_data),
		.read_a       (reg_a),
		.read_b       (reg_b)
	);

	alu alu0 (
		.operand_a (reg_a),
		.operand_b (operand_b),
		.res_sel   (ctrl.res_sel),
		.sub_op    (ctrl.sub_op),
		.result    (alu_result)
	);

	assign instr    = ir;
	assign im_addr  = pc;
	assign dm_addr  = addr_q;
	assign dm_wdata = reg_b;

endmodule

`default_nettype wire

/* hw/cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
	input  logic           clock,
	input  logic           reset,
	output logic           im_enable,
	output cpu_pkg::word_t im_addr,
	input  cpu_pkg::word_t im_rdata,
	output logic           dm_enable,
	output logic           dm_read,
	output logic           dm_write,
	output cpu_pkg::word_t dm_addr,
	output cpu_pkg::word_t dm_wdata,
	input  cpu_pkg::word_t dm_rdata
);
	import cpu_pkg::*;

	word_t instr;
	logic  pc_enable;
	logic  fetch_enable;
	logic  execute_enable;
	logic  writeback_enable;

	ctrl_if ctrl_bus ();

	controller ctrl0 (
		.clock            (clock),
		.reset            (reset),
		.instr            (instr),
		.ctrl             (ctrl_bus.master),
		.pc_enable        (pc_enable),
		.fetch_enable     (fetch_enable),
		.execute_enable   (execute_enable),
		.writeback_enable (writeback_enable),
		.im_enable        (im_enable),
		.dm_enable        (dm_enable)
	);

	datapath data0 (
		.clock            (clock),
		.reset            (reset),
		.ctrl             (ctrl_bus.slave),
		.pc_enable        (pc_enable),
		.fetch_enable     (fetch_enable),
		.execute_enable   (execute_enable),
		.writeback_enable (writeback_enable),
		.instr            (instr),
		.im_addr          (im_addr),
		.im_rdata         (im_rdata),
		.dm_addr          (dm_addr),
		.dm_wdata         (dm_wdata),
		.dm_rdata         (dm_rdata)
	);

	// already phase gated in the controller
	assign dm_read  = ctrl_bus.dm_read;
	assign dm_write = ctrl_bus.dm_write;

endmodule

`default_nettype wire

/* tb/cpu_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_properties (
	input logic clock,
	input logic reset,
	input logic im_enable,
	input logic dm_enable,
	input logic dm_read,
	input logic dm_write
);

	// position within the five cycle instruction
	logic [2:0] gap;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			gap <= '0;
		end else if (gap == 3'd4) begin
			gap <= '0;
		end else begin
			gap <= gap + 3'd1;
		end
	end

	no_im_dm_overlap: assert property (@(posedge clock) disable iff (reset)
		!(im_enable && dm_enable))
		else $error("im_enable and dm_enable high together");

	no_read_write_overlap: assert property (@(posedge clock) disable iff (reset)
		!(dm_read && dm_write))
		else $error("dm_read and dm_write high together");

	fetch_every_fifth: assert property (@(posedge clock) disable iff (reset)
		im_enable == (gap == 3'd0))
		else $error("im_enable out of its five cycle slot");

endmodule

bind controller cpu_properties props0 (
	.clock     (clock),
	.reset     (reset),
	.im_enable (im_enable),
	.dm_enable (dm_enable),
	.dm_read   (ctrl.dm_read),
	.dm_write  (ctrl.dm_write)
);

`default_nettype wire

/* tb/cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;
	import cpu_pkg::*;

	// word offsets in the vector file
	localparam logic [7:0] prog_base  = 8'h10;
	localparam logic [7:0] data_base  = 8'h60;
	localparam logic [7:0] store_base = 8'h80;
	localparam logic [7:0] count_slot = 8'hff;

	logic  clock;
	logic  reset;
	logic  im_enable;
	logic  dm_enable;
	logic  dm_read;
	logic  dm_write;
	word_t im_addr;
	word_t im_rdata;
	word_t dm_addr;
	word_t dm_wdata;
	word_t dm_rdata;

	word_t vectors [256];
	word_t imem [256];
	word_t dmem [64];
	word_t prog_len;
	word_t data_len;
	word_t exp_count;
	word_t store_count;
	word_t fetch_addr;
	int    instr_cycle;
	logic  loaded;
	logic  program_done;

	cpu_top dut0 (
		.clock     (clock),
		.reset     (reset),
		.im_enable (im_enable),
		.im_addr   (im_addr),
		.im_rdata  (im_rdata),
		.dm_enable (dm_enable),
		.dm_read   (dm_read),
		.dm_write  (dm_write),
		.dm_addr   (dm_addr),
		.dm_wdata  (dm_wdata),
		.dm_rdata  (dm_rdata)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	task automatic compare_values(input word_t actual, input word_t expected, input string what);
		if (actual !== expected) begin
			$display("Fail at %0t: %s, got %h, expected %h", $time, what, actual, expected);
			$display("TESTS FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic record_store(input word_t addr, input word_t data);
		if (store_count >= exp_count) begin
			$display("An unexpected extra store to address %h happened at %0t", addr, $time);
			$display("TESTS FAILED");
			$fatal(1, "extra store");
		end else begin
			compare_values(addr, vectors[store_base + 8'(2 * store_count)], "store address");
			compare_values(data, vectors[store_base + 8'(2 * store_count + 1)], "store data");
			dmem[addr[7:2]] = data;
			store_count = store_count + 1;
		end
	endtask

	// outputs sampled mid cycle
	// memories answer just after the next edge
	always begin : memory_model
		logic  active;
		logic  im_en;
		logic  dm_en;
		logic  rd;
		logic  wr;
		word_t ia;
		word_t da;
		word_t wd;
		@(negedge clock);
		active = !reset;
		im_en  = im_enable;
		dm_en  = dm_enable;
		rd     = dm_read;
		wr     = dm_write;
		ia     = im_addr;
		da     = dm_addr;
		wd     = dm_wdata;
		@(posedge clock);
		#1;
		if (active) begin
			compare_values(word_t'(im_en), word_t'(instr_cycle == 0), "im_enable position");
			compare_values(word_t'(dm_en), word_t'(instr_cycle == 3), "dm_enable position");
			if (rd) compare_values(instr_cycle, 32'd3, "dm_read cycle in instruction");
			if (wr) compare_values(instr_cycle, 32'd3, "dm_write cycle in instruction");
			if (im_en) begin
				compare_values(ia, fetch_addr, "fetch address");
				im_rdata = imem[ia[9:2]];
				if (ia == prog_len * 4) program_done = 1'b1;
				fetch_addr = fetch_addr + 32'd4;
			end
			if (dm_en && rd) dm_rdata = dmem[da[7:2]];
			if (dm_en && wr) record_store(da, wd);
			instr_cycle = (instr_cycle == 4) ? 0 : instr_cycle + 1;
		end
	end

	initial begin : watchdog
		wait (loaded);
		// five cycles per instruction plus slack
		repeat (5 * prog_len + 40) @(posedge clock);
		$display("Timeout: the program did not finish within %0d cycles", 5 * prog_len + 40);
		$display("TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin : main_sequence
		void'($urandom(32'hef48));
		reset        = 1'b1;
		im_rdata     = '0;
		dm_rdata     = '0;
		loaded       = 1'b0;
		program_done = 1'b0;
		store_count  = '0;
		fetch_addr   = '0;
		instr_cycle  = 0;

		$readmemh("tb/cpu_vectors.txt", vectors);
		prog_len  = vectors[8'h00];
		data_len  = vectors[8'h01];
		exp_count = vectors[count_slot];
		compare_values(word_t'(prog_len != 0 && prog_len <= 80), 32'd1, "program length");
		compare_values(word_t'(data_len <= 32), 32'd1, "data length");
		compare_values(word_t'(exp_count <= 63), 32'd1, "store count");

		// nop beyond the program
		for (int i = 0; i < 256; i++) begin
			imem[i] = {1'b0, op_ty_base, 20'd0, sub_srli};
		end
		for (int i = 0; i < prog_len; i++) begin
			imem[i] = vectors[prog_base + 8'(i)];
		end
		for (int i = 0; i < 64; i++) begin
			dmem[i] = $urandom;
		end
		for (int i = 0; i < data_len; i++) begin
			dmem[i] = vectors[data_base + 8'(i)];
		end
		loaded = 1'b1;

		repeat (2) @(posedge clock);
		#1 reset = 1'b0;

		wait (program_done);
		compare_values(store_count, exp_count, "number of stores");
		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/cpu_vectors.txt */
// @00 program length, data length; @10 program words; @60 initial data words from address 0
// @80 expected stores in order, each as address then data; @ff number of stores
@00
0000002B
0000000A
@10
44112345 // movi r1, 0x12345
442FFFFD // movi r2, -3
44380000 // movi r3, 0x80000
40408800 // add r4, r1, r2
40508801 // sub r5, r1, r2
40610C02 // and r6, r2, r3
40708C04 // or r7, r1, r3
40808803 // xor r8, r1, r2
40939009 // srli r9, r7, 4
40A0B008 // slli r10, r1, 12
40B0A00B // rotri r11, r1, 8
50C0FFFB // addi r12, r1, -5
58D0FF00 // ori r13, r1, 0x7f00
56E17FFF // xori r14, r2, 0x7fff
44000007 // movi r0, 7
45000004 // movi r16, 4
45500080 // movi r21, 0x80
04F80005 // lwi r15, [r16 + 20]
39184002 // lw r17, [r16 + r16]
39284102 // lw r18, [r16 + (r16 << 1)]
39384202 // lw r19, [r16 + (r16 << 2)]
39484302 // lw r20, [r16 + (r16 << 3)]
14200010 // swi r2, [0x40]
14400011 // swi r4
14500012 // swi r5
14600013 // swi r6
14700014 // swi r7
14800015 // swi r8
14900016 // swi r9
14A00017 // swi r10
14B00018 // swi r11
14C00019 // swi r12
14D0001A // swi r13
14E0001B // swi r14
1400001C // swi r0
14F0001D // swi r15
1510001E // swi r17
1520001F // swi r18
393AC00A // sw r19, [r21 + r16]
394AC20A // sw r20, [r21 + (r16 << 2)]
66111234 // unknown opcode, rt r1
4010881F // unknown base sub-opcode, rt r1
14100020 // swi r1, [0x80]
@60
12345678
9ABCDEF0
0BADF00D
CAFE1234
00C0FFEE
76543210
DEADBEEF
5A5AA5A5
0F1E2D3C
13579BDF
@80
00000040 FFFFFFFD
00000044 00012342
00000048 00012348
0000004C FFF80000
00000050 FFF92345
00000054 FFFEDCB8
00000058 0FFF9234
0000005C 12345000
00000060 45000123
00000064 00012340
00000068 00017F45
0000006C FFFF8002
00000070 00000000
00000074 DEADBEEF
00000078 0BADF00D
0000007C CAFE1234
00000084 76543210
00000090 13579BDF
00000080 00012345
@FF
00000013

/* flist.f */
hw/cpu_pkg.sv
hw/ctrl_if.sv
hw/regfile.sv
hw/alu.sv
hw/controller.sv
hw/datapath.sv
hw/cpu_top.sv
tb/cpu_properties.sv
tb/cpu_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, then judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module cpu_tb -f flist.f -o cpu_sim > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }
./obj_dir/cpu_sim > sim.log 2>&1; cat sim.log
! grep -q "TESTS FAILED" sim.log && grep -q "TESTS PASSED" sim.log
